/* logic/mb20_config.svh */
////////////////////////////////////////
// Sizes and register codes for one MB20 box
// LOCAL_BITS must stay below ADDR_BITS
////////////////////////////////////////
`ifndef MB20_CONFIG_SVH
`define MB20_CONFIG_SVH

// Bus word address, MEM ADR 14-35
`define MB20_ADDR_BITS 22

// Address bits decoded inside the box
`define MB20_LOCAL_BITS 12

// Upper address bits compared against the base switches
`define MB20_BASE_BITS (`MB20_ADDR_BITS - `MB20_LOCAL_BITS)

// Words held in the core array
`define MB20_MEM_WORDS (1 << `MB20_LOCAL_BITS)

// Data word width
`define MB20_WORD_BITS 36

// Configuration register selectors
`define MB20_SEL_BASE 2'd0
`define MB20_SEL_ENABLE 2'd1
`define MB20_SEL_COUNT 2'd2

`endif

/* logic/kl10MemPkg.sv */
////////////////////////////////////////
// Memory path types, sized from mb20_config.svh
////////////////////////////////////////
`default_nettype none

`include "mb20_config.svh"

package kl10MemPkg;

  // One 36-bit KL10 word
  typedef logic [`MB20_WORD_BITS-1:0] tWord36;

  // Full bus word address
  typedef logic [`MB20_ADDR_BITS-1:0] tMemAddr;

  // Index into the core array of this box
  typedef logic [`MB20_LOCAL_BITS-1:0] tLocalAddr;

  // Upper address bits that select this box
  typedef logic [`MB20_BASE_BITS-1:0] tBaseAddr;

  // MEM RQ 0-3, bit k asks for quad slot k
  typedef logic [3:0] tRqMask;

endpackage

`default_nettype wire

/* logic/mb20CyclePkg.sv */
////////////////////////////////////////
// Sequencer and config port types
////////////////////////////////////////
`default_nettype none

package mb20CyclePkg;

  // Phase sequencer states
  // ACKN and DATA alternate per slot, DONE is the last data slot
  typedef enum logic [1:0] {
    IDLE,
    ACKN,
    DATA,
    DONE
  } tPhaseState;

  // Configuration register select
  typedef logic [1:0] tCfgSel;

endpackage

`default_nettype wire

/* logic/mb20Control.sv */
////////////////////////////////////////
// Base, enable and cycle count registers
// Writes land on the next edge, readback is combinational
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mb20_config.svh"

module mb20Control (
  input  wire logic                 mbus,
  input  wire logic                 reset,
  input  wire logic                 cfgWrite,
  input  wire mb20CyclePkg::tCfgSel cfgSel,
  input  wire kl10MemPkg::tWord36   cfgData,
  input  wire logic                 acceptedA,
  input  wire logic                 acceptedB,
  output kl10MemPkg::tWord36        cfgRdData,
  output kl10MemPkg::tBaseAddr      baseAddr,
  output logic                      memEnable
);

  import kl10MemPkg::*;

  // Accepted cycles from both phases
  tWord36 cycleCount;

  // Strobe decodes for each register
  logic wrBase;
  logic wrEnable;
  logic wrCount;

  assign wrBase   = cfgWrite && (cfgSel == `MB20_SEL_BASE);
  assign wrEnable = cfgWrite && (cfgSel == `MB20_SEL_ENABLE);
  assign wrCount  = cfgWrite && (cfgSel == `MB20_SEL_COUNT);

  // Switch-style base and enable bit steer both sequencers
  always_ff @(posedge mbus) begin
    if (reset) begin
      baseAddr  <= '0;
      memEnable <= 1'b0;
    end else begin
      if (wrBase) begin
        baseAddr <= tBaseAddr'(cfgData);
      end
      if (wrEnable) begin
        memEnable <= cfgData[0];
      end
    end
  end

  // Both phases may accept on the same edge, so add each strobe
  always_ff @(posedge mbus) begin
    if (reset || wrCount) begin
      cycleCount <= '0;
    end else begin
      cycleCount <= cycleCount + tWord36'(acceptedA) + tWord36'(acceptedB);
    end
  end

  // Readback of the selected register
  always_comb begin
    case (cfgSel)
      `MB20_SEL_BASE:   cfgRdData = tWord36'(baseAddr);
      `MB20_SEL_ENABLE: cfgRdData = tWord36'(memEnable);
      `MB20_SEL_COUNT:  cfgRdData = cycleCount;
      default:          cfgRdData = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/mb20Store.sv */
////////////////////////////////////////
// Core array, one port per phase, not reset
// Reads are registered, read during write sees old data
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mb20_config.svh"

module mb20Store (
  input  wire logic                  mbus,
  input  wire kl10MemPkg::tLocalAddr addrA,
  input  wire kl10MemPkg::tLocalAddr addrB,
  input  wire logic                  writeA,
  input  wire logic                  writeB,
  input  wire kl10MemPkg::tWord36    wDataA,
  input  wire kl10MemPkg::tWord36    wDataB,
  output kl10MemPkg::tWord36         rDataA,
  output kl10MemPkg::tWord36         rDataB,
  output logic                       parityA,
  output logic                       parityB
);

  import kl10MemPkg::*;

  // The core itself
  tWord36 mem [0:`MB20_MEM_WORDS-1];

  // Phase A and phase B ports, writes and registered reads on one edge
  always_ff @(posedge mbus) begin
    if (writeA) begin
      mem[addrA] <= wDataA;
    end
    if (writeB) begin
      mem[addrB] <= wDataB;
    end
    rDataA <= mem[addrA];
    rDataB <= mem[addrB];
  end

  // Odd parity over word plus parity bit
  assign parityA = ~^rDataA;
  assign parityB = ~^rDataB;

  // The two sequencers share no arbiter, so a same-word write would be lost
  property pNoWriteCollision;
    @(posedge mbus) !(writeA && writeB && (addrA == addrB));
  endproperty

  aNoWriteCollision: assert property (pNoWriteCollision)
    else $error("MB20 store: both phases write word %0h in one cycle", addrA);

endmodule

`default_nettype wire

/* logic/mb20Phase.sv */
////////////////////////////////////////
// One bus phase, quad cycles only, no read-pause-write
// A start while busy is dropped
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mb20_config.svh"

module mb20Phase (
  input  wire logic                 mbus,
  input  wire logic                 reset,
  input  wire logic                 start,
  input  wire logic                 rdRq,
  input  wire logic                 wrRq,
  input  wire kl10MemPkg::tMemAddr  adr,
  input  wire kl10MemPkg::tRqMask   rq,
  input  wire kl10MemPkg::tWord36   dOut,
  input  wire logic                 validOut,
  input  wire kl10MemPkg::tBaseAddr baseAddr,
  input  wire logic                 memEnable,
  input  wire kl10MemPkg::tWord36   portRData,
  input  wire logic                 portParity,
  output logic                      ackn,
  output logic                      validIn,
  output kl10MemPkg::tWord36        dIn,
  output logic                      parIn,
  output logic                      accepted,
  output kl10MemPkg::tLocalAddr     portAddr,
  output logic                      portWrite,
  output kl10MemPkg::tWord36        portWData
);

  import kl10MemPkg::*;
  import mb20CyclePkg::*;

  tPhaseState state;

  // Slot being worked on, 0..3
  logic [1:0] slot;

  // Latched at start
  tRqMask    mask;
  logic      isWrite;
  tLocalAddr startLocal;

  // Start qualification
  logic addrHit;
  logic oneKind;
  logic accept;

  // Slot decode
  logic       slotReq;
  logic       dataSlot;
  logic [1:0] wordLo;

  // Upper bits must land on this box
  assign addrHit = (adr[`MB20_ADDR_BITS-1:`MB20_LOCAL_BITS] == baseAddr);
  // Read-pause-write is not served
  assign oneKind = rdRq ^ wrRq;
  assign accept  = start && (state == IDLE) && memEnable && oneKind && addrHit;

  always_ff @(posedge mbus) begin
    if (reset) begin
      state    <= IDLE;
      slot     <= '0;
      accepted <= 1'b0;
    end else begin
      accepted <= accept;
      case (state)
        IDLE: begin
          slot <= '0;
          if (accept) begin
            state <= ACKN;
          end
        end
        // Last slot's data cycle is DONE, so IDLE lands at T+9
        ACKN: state <= (slot == 2'd3) ? DONE : DATA;
        DATA: begin
          slot  <= slot + 2'd1;
          state <= ACKN;
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Cycle parameters, only looked at while busy
  always_ff @(posedge mbus) begin
    if (accept) begin
      mask       <= rq;
      isWrite    <= wrRq;
      startLocal <= adr[`MB20_LOCAL_BITS-1:0];
    end
  end

  assign slotReq  = mask[slot];
  assign dataSlot = (state == DATA) || (state == DONE);

  // Word within the quad wraps, upper local bits stay
  assign wordLo   = startLocal[1:0] + slot;
  assign portAddr = {startLocal[`MB20_LOCAL_BITS-1:2], wordLo};

  // Address goes out in ACKN so read data is ready in the data cycle
  assign ackn    = (state == ACKN) && slotReq;
  assign validIn = dataSlot && !isWrite && slotReq;

  // Bus data is quiet outside valid read slots
  assign dIn   = validIn ? portRData : '0;
  assign parIn = validIn && portParity;

  // Write data only stored when the requester marks it valid
  assign portWrite = dataSlot && isWrite && slotReq && validOut;
  assign portWData = portWrite ? dOut : '0;

  // Requester started a new cycle before this one finished
  property pNoStartWhenBusy;
    @(posedge mbus) disable iff (reset) start |-> (state == IDLE);
  endproperty

  aNoStartWhenBusy: assert property (pNoStartWhenBusy)
    else $warning("MB20 phase %m: start while busy, ignored");

  // validOut belongs in the data cycle of an accepted write
  property pValidOutInWriteSlot;
    @(posedge mbus) disable iff (reset) validOut |-> (dataSlot && isWrite);
  endproperty

  aValidOutInWriteSlot: assert property (pValidOutInWriteSlot)
    else $error("MB20 phase %m: validOut outside a write data slot");

endmodule

`default_nettype wire

/* logic/mb20.sv */
////////////////////////////////////////
// MB20 box, both phases on rising mbus
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mb20 (
  input  wire logic                 mbus,
  input  wire logic                 reset,
  input  wire kl10MemPkg::tMemAddr  adr,
  input  wire kl10MemPkg::tRqMask   rq,
  input  wire logic                 rdRq,
  input  wire logic                 wrRq,
  input  wire kl10MemPkg::tWord36   dOut,
  input  wire logic                 startA,
  input  wire logic                 startB,
  input  wire logic                 validOutA,
  input  wire logic                 validOutB,
  output logic                      acknA,
  output logic                      acknB,
  output logic                      validInA,
  output logic                      validInB,
  output kl10MemPkg::tWord36        dInA,
  output kl10MemPkg::tWord36        dInB,
  output logic                      parInA,
  output logic                      parInB,
  input  wire logic                 cfgWrite,
  input  wire mb20CyclePkg::tCfgSel cfgSel,
  input  wire kl10MemPkg::tWord36   cfgData,
  output kl10MemPkg::tWord36        cfgRdData
);

  import kl10MemPkg::*;

  // Steering from the register block
  tBaseAddr baseAddr;
  logic     memEnable;
  logic     acceptedA;
  logic     acceptedB;

  // Store ports, one per phase
  tLocalAddr addrA;
  tLocalAddr addrB;
  logic      writeA;
  logic      writeB;
  tWord36    wDataA;
  tWord36    wDataB;
  tWord36    rDataA;
  tWord36    rDataB;
  logic      parityA;
  logic      parityB;

  mb20Control u_control (
    .mbus      (mbus),
    .reset     (reset),
    .cfgWrite  (cfgWrite),
    .cfgSel    (cfgSel),
    .cfgData   (cfgData),
    .acceptedA (acceptedA),
    .acceptedB (acceptedB),
    .cfgRdData (cfgRdData),
    .baseAddr  (baseAddr),
    .memEnable (memEnable)
  );

  mb20Store u_store (
    .mbus    (mbus),
    .addrA   (addrA),
    .addrB   (addrB),
    .writeA  (writeA),
    .writeB  (writeB),
    .wDataA  (wDataA),
    .wDataB  (wDataB),
    .rDataA  (rDataA),
    .rDataB  (rDataB),
    .parityA (parityA),
    .parityB (parityB)
  );

  // Address, mask and kind lines are shared, start tells the phases apart
  mb20Phase u_phaseA (
    .mbus       (mbus),
    .reset      (reset),
    .start      (startA),
    .rdRq       (rdRq),
    .wrRq       (wrRq),
    .adr        (adr),
    .rq         (rq),
    .dOut       (dOut),
    .validOut   (validOutA),
    .baseAddr   (baseAddr),
    .memEnable  (memEnable),
    .portRData  (rDataA),
    .portParity (parityA),
    .ackn       (acknA),
    .validIn    (validInA),
    .dIn        (dInA),
    .parIn      (parInA),
    .accepted   (acceptedA),
    .portAddr   (addrA),
    .portWrite  (writeA),
    .portWData  (wDataA)
  );

  mb20Phase u_phaseB (
    .mbus       (mbus),
    .reset      (reset),
    .start      (startB),
    .rdRq       (rdRq),
    .wrRq       (wrRq),
    .adr        (adr),
    .rq         (rq),
    .dOut       (dOut),
    .validOut   (validOutB),
    .baseAddr   (baseAddr),
    .memEnable  (memEnable),
    .portRData  (rDataB),
    .portParity (parityB),
    .ackn       (acknB),
    .validIn    (validInB),
    .dIn        (dInB),
    .parIn      (parInB),
    .accepted   (acceptedB),
    .portAddr   (addrB),
    .portWrite  (writeB),
    .portWData  (wDataB)
  );

endmodule

`default_nettype wire

/* testbench/mb20Tb.sv */
////////////////////////////////////////
// Run from the project root, vectors in testbench/
// Reads only touch words an earlier line wrote
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mb20_config.svh"

module mb20Tb;

  import kl10MemPkg::*;
  import mb20CyclePkg::*;

  logic    mbus;
  logic    reset;
  tMemAddr adr;
  tRqMask  rq;
  logic    rdRq;
  logic    wrRq;
  tWord36  dOut;
  logic    startA;
  logic    startB;
  logic    validOutA;
  logic    validOutB;
  logic    acknA;
  logic    acknB;
  logic    validInA;
  logic    validInB;
  tWord36  dInA;
  tWord36  dInB;
  logic    parInA;
  logic    parInB;
  logic    cfgWrite;
  tCfgSel  cfgSel;
  tWord36  cfgData;
  tWord36  cfgRdData;

  // Expected core contents, keyed by bus address
  tWord36 model [tMemAddr];
  integer seed = 32'h15ec;
  int     acceptedTally;
  int     opsRun;

  mb20 u_mb20 (.*);

  initial begin
    mbus = 1'b0;
    forever #50 mbus = ~mbus;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      failRun($sformatf("** Error at time %0t: %s expected %0h, actual %0h",
                        $time, name, expected, actual));
    end
  endtask

  // {ackn, validIn, parIn, dIn} of one phase
  function automatic logic [38:0] phaseOut(input int ph);
    return (ph != 0) ? {acknB, validInB, parInB, dInB} : {acknA, validInA, parInA, dInA};
  endfunction

  // Parity bit giving an odd count of ones over all 37 bits
  function automatic logic oddParity(input tWord36 w);
    int ones;
    ones = 0;
    for (int i = 0; i < `MB20_WORD_BITS; i++) begin
      ones += w[i];
    end
    return (ones % 2) == 0;
  endfunction

  function automatic tWord36 nextWord(input tWord36 mix);
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[35:0] ^ mix;
  endfunction

  task automatic setStart(input int ph, input logic v);
    if (ph == 0) begin
      startA = v;
    end else begin
      startB = v;
    end
  endtask

  task automatic setValidOut(input int ph, input logic v);
    if (ph == 0) begin
      validOutA = v;
    end else begin
      validOutB = v;
    end
  endtask

  // One-cycle start strobe, returns at the first negedge after it is sampled
  task automatic driveStart(input int ph, input logic rd, input logic wr,
                            input tMemAddr a, input tRqMask m);
    @(negedge mbus);
    adr  = a;
    rq   = m;
    rdRq = rd;
    wrRq = wr;
    setStart(ph, 1'b1);
    @(negedge mbus);
    setStart(ph, 1'b0);
  endtask

  // No data is valid before the first requested slot
  task automatic waitForAckn(input int ph, input int limit, output int cyc);
    logic [38:0] o;
    cyc = 1;
    o = phaseOut(ph);
    while (!o[38]) begin
      checkValue((ph != 0) ? "validInB" : "validInA", 0, o[37]);
      if (cyc >= limit) begin
        failRun($sformatf("Timeout: ackn%s never arrived", (ph != 0) ? "B" : "A"));
      end
      @(negedge mbus);
      cyc++;
      o = phaseOut(ph);
    end
  endtask

  // Cycle n after the start edge: odd n is an ackn slot, even n a data slot
  task automatic serveSlots(input int ph, input logic wr, input tMemAddr a,
                            input tRqMask m, input logic strobe, input tWord36 mix);
    string       tag;
    logic [38:0] o;
    tMemAddr     wa;
    tWord36      w;
    int          first;
    int          c;
    int          k;
    tag = (ph != 0) ? "B" : "A";
    first = 0;
    while (first < 3 && !m[first]) begin
      first++;
    end
    waitForAckn(ph, 12, c);
    checkValue({"ackn", tag, " first slot cycle"}, 1 + 2 * first, c);
    for (int n = c; n <= 9; n++) begin
      if (n > c) begin
        @(negedge mbus);
      end
      o = phaseOut(ph);
      if (n % 2 == 1) begin
        k = (n - 1) / 2;
        setValidOut(ph, 1'b0);
        checkValue({"ackn", tag}, (n < 9) && m[k], o[38]);
        checkValue({"validIn", tag}, 0, o[37]);
        checkValue({"dIn", tag}, 0, o[35:0]);
      end else begin
        k = (n - 2) / 2;
        // Low two bits wrap inside the quad
        wa = a;
        wa[1:0] = a[1:0] + k[1:0];
        checkValue({"ackn", tag}, 0, o[38]);
        checkValue({"validIn", tag}, !wr && m[k], o[37]);
        if (!wr && m[k]) begin
          if (!model.exists(wa)) begin
            failRun($sformatf("Vector reads word %0h that was never written", wa));
          end
          checkValue({"dIn", tag}, model[wa], o[35:0]);
          checkValue({"parIn", tag}, oddParity(model[wa]), o[36]);
        end
        if (wr && m[k] && strobe) begin
          w = nextWord(mix);
          dOut = w;
          setValidOut(ph, 1'b1);
          model[wa] = w;
        end
      end
    end
  endtask

  task automatic expectNoAckn(input int ph, input int cycles);
    logic [38:0] o;
    for (int n = 0; n < cycles; n++) begin
      if (n > 0) begin
        @(negedge mbus);
      end
      o = phaseOut(ph);
      if (o[38]) begin
        failRun($sformatf("Phase %s acknowledged a start that should be rejected",
                          (ph != 0) ? "B" : "A"));
      end
    end
  endtask

  task automatic readConfig(input tCfgSel sel, input tWord36 expected);
    @(negedge mbus);
    cfgSel = sel;
    @(negedge mbus);
    checkValue("cfgRdData", expected, cfgRdData);
  endtask

  // Write lands on the next edge, readback stays on the same select
  task automatic writeConfig(input tCfgSel sel, input tWord36 data);
    tWord36 expected;
    case (sel)
      `MB20_SEL_BASE:   expected = data & ((36'd1 << `MB20_BASE_BITS) - 1);
      `MB20_SEL_ENABLE: expected = tWord36'(data[0]);
      default: begin
        expected = '0;
        acceptedTally = 0;
      end
    endcase
    @(negedge mbus);
    cfgSel   = sel;
    cfgData  = data;
    cfgWrite = 1'b1;
    @(negedge mbus);
    cfgWrite = 1'b0;
    checkValue("cfgRdData", expected, cfgRdData);
  endtask

  task automatic runOp(input string op, input int ph, input tWord36 av,
                       input tRqMask m, input tWord36 sv);
    tMemAddr a;
    a = tMemAddr'(av);
    case (op)
      "cfg":   writeConfig(tCfgSel'(ph), av);
      "chk":   readConfig(tCfgSel'(ph), av);
      "count": readConfig(`MB20_SEL_COUNT, tWord36'(acceptedTally));
      "wr", "wrx": begin
        driveStart(ph, 1'b0, 1'b1, a, m);
        serveSlots(ph, 1'b1, a, m, op == "wr", sv);
        acceptedTally++;
      end
      "rd": begin
        driveStart(ph, 1'b1, 1'b0, a, m);
        serveSlots(ph, 1'b0, a, m, 1'b0, '0);
        acceptedTally++;
      end
      "probe": begin
        driveStart(ph, 1'b1, 1'b0, a, m);
        expectNoAckn(ph, 10);
      end
      "both": begin
        driveStart(ph, 1'b1, 1'b1, a, m);
        expectNoAckn(ph, 10);
      end
      "busy": begin
        // Second start lands two cycles into a running read
        fork
          begin
            driveStart(ph, 1'b1, 1'b0, a, m);
            serveSlots(ph, 1'b0, a, m, 1'b0, '0);
          end
          begin
            repeat (2) @(negedge mbus);
            driveStart(ph, 1'b0, 1'b1, a ^ 22'h40, 4'hf);
          end
        join
        acceptedTally++;
      end
      "ovl": begin
        // Phase B starts one cycle behind A, so dOut never serves both
        fork
          begin
            driveStart(0, 1'b0, 1'b1, a, m);
            serveSlots(0, 1'b1, a, m, 1'b1, av);
          end
          begin
            @(negedge mbus);
            driveStart(1, 1'b1, 1'b0, tMemAddr'(sv), 4'hf);
            serveSlots(1, 1'b0, tMemAddr'(sv), 4'hf, 1'b0, '0);
          end
        join
        acceptedTally += 2;
      end
      default: failRun({"Unknown vector opcode ", op});
    endcase
  endtask

  initial begin
    integer fd;
    string  line;
    string  op;
    int     ph;
    tWord36 av;
    tWord36 mv;
    tWord36 sv;
    int     got;
    reset     = 1'b1;
    adr       = '0;
    rq        = '0;
    rdRq      = 1'b0;
    wrRq      = 1'b0;
    dOut      = '0;
    startA    = 1'b0;
    startB    = 1'b0;
    validOutA = 1'b0;
    validOutB = 1'b0;
    cfgWrite  = 1'b0;
    cfgSel    = '0;
    cfgData   = '0;
    acceptedTally = 0;
    opsRun = 0;
    repeat (8) @(negedge mbus);
    reset = 1'b0;
    // Both phases quiet with dIn at zero
    checkValue("phase A outputs", 0, phaseOut(0));
    checkValue("phase B outputs", 0, phaseOut(1));
    fd = $fopen("testbench/mb20_vectors.txt", "r");
    if (fd == 0) begin
      failRun("Could not open testbench/mb20_vectors.txt");
    end
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      if (got == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if ($sscanf(line, "%s %d %h %h %h", op, ph, av, mv, sv) != 5) begin
        failRun({"Malformed vector line ", line});
      end
      runOp(op, ph, av, tRqMask'(mv), sv);
      opsRun++;
    end
    $fclose(fd);
    if (opsRun == 0) begin
      failRun("Vector file held no operations");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/mb20_vectors.txt */
# op ph addr mask seed, all hex except ph; cfg and chk use ph as register select, addr as data
# ovl: phase A writes addr with mask while phase B reads the quad at seed one cycle later
chk 1 0 0 0
chk 0 0 0 0
chk 2 0 0 0
probe 0 000010 f 0
probe 1 000010 f 0
cfg 0 fff0a3 0 0
cfg 1 1 0 0
chk 0 0a3 0 0
chk 1 1 0 0
wr 0 0a3010 f 1111
rd 0 0a3010 f 0
wr 0 0a3024 f 2222
wr 0 0a3026 5 3333
rd 0 0a3024 f 0
wr 0 0a3030 f 4444
wr 0 0a3031 a 5555
rd 0 0a3033 f 0
rd 0 0a3032 6 0
wr 1 0a3040 f 6666
rd 1 0a3042 f 0
ovl 0 0a3050 f 0a3040
rd 1 0a3050 f 0
wrx 1 0a3010 f 7777
ovl 0 0a3014 3 0a3010
rd 0 0a3014 3 0
count 0 0 0 0
probe 0 0a4010 f 0
probe 1 1a3010 f 0
both 0 0a3010 f 0
both 1 0a3024 f 0
busy 0 0a3024 f 0
busy 1 0a3030 9 0
count 0 0 0 0
cfg 2 0 0 0
rd 1 0a3025 f 0
count 0 0 0 0
cfg 1 0 0 0
probe 0 0a3010 f 0

/* build.f */
+incdir+logic
logic/kl10MemPkg.sv
logic/mb20CyclePkg.sv
logic/mb20Control.sv
logic/mb20Store.sv
logic/mb20Phase.sv
logic/mb20.sv
testbench/mb20Tb.sv
